// File: mem_op_pkg.sv
`default_nettype none

package mem_op_pkg;

	// data and address width
	parameter int XLEN = 32;
	parameter int ROB_ID_BITS = 5;

	typedef logic [ROB_ID_BITS-1:0] rob_id_t;

	// access size of a load or store
	typedef enum logic [1:0] {
		BYTE = 2'h0,
		HALF = 2'h1,
		WORD = 2'h2
	} mem_size_t;

	// one memory op leaving dispatch in program order
	typedef struct packed {
		logic      valid;
		logic      is_store;
		rob_id_t   rob_id;
		mem_size_t size;
		logic      is_signed;
	} dispatch_t;

	// load finished in execute, mem_data is the raw value read from memory
	typedef struct packed {
		logic            valid;
		rob_id_t         rob_id;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] mem_data;
	} exec_load_t;

	// store address and data resolved in execute
	typedef struct packed {
		logic            valid;
		rob_id_t         rob_id;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
	} exec_store_t;

	// extended load value back to the core
	typedef struct packed {
		logic            valid;
		rob_id_t         rob_id;
		logic [XLEN-1:0] data;
		logic            forwarded;
	} load_result_t;

	// retiring store toward the data cache
	typedef struct packed {
		logic            valid;
		logic [XLEN-1:0] addr;
		logic [XLEN-1:0] data;
		mem_size_t       size;
	} store_commit_t;

endpackage

`default_nettype wire

// File: lsq_pkg.sv
`default_nettype none

package lsq_pkg;

	// widest ring pointer, 4 index bits for depth 16 plus the wrap bit
	parameter int PTR_BITS = 5;

	// shallower queues zero-extend their pointers into this type
	typedef logic [PTR_BITS-1:0] qptr_t;

	// load row
	// store_tail marks the first store younger than this load
	typedef struct packed {
		mem_op_pkg::mem_size_t             size;
		logic                              is_signed;
		logic [mem_op_pkg::XLEN-1:0]       addr;
		logic [mem_op_pkg::XLEN-1:0]       mem_data;
		qptr_t                             store_tail;
	} lq_entry_t;

	// store row
	typedef struct packed {
		mem_op_pkg::mem_size_t             size;
		logic [mem_op_pkg::XLEN-1:0]       addr;
		logic [mem_op_pkg::XLEN-1:0]       data;
	} sq_entry_t;

endpackage

`default_nettype wire

// File: queue_pointers.sv
`timescale 1ns/100ps
`default_nettype none

module queue_pointers #(
	parameter int DEPTH = 8
) (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire logic                   push,
	input  wire logic                   pop,
	output lsq_pkg::qptr_t              head,
	output lsq_pkg::qptr_t              tail,
	output logic [lsq_pkg::PTR_BITS-1:0] free,
	output logic                        full,
	output logic                        empty
);
	import lsq_pkg::*;

	// index bits, the extra top bit is the wrap bit
	localparam int IDX = $clog2(DEPTH);

	logic [IDX:0] head_q;
	logic [IDX:0] tail_q;
	logic [IDX:0] count;

	// occupancy from the wrap-bit distance
	assign count = tail_q - head_q;
	// head == tail with differing wrap bits means full
	assign full  = (count == (IDX+1)'(DEPTH));
	assign empty = (count == '0);
	assign free  = PTR_BITS'(DEPTH) - PTR_BITS'(count);

	// upper pointer bits stay zero for shallow queues
	assign head = qptr_t'(head_q);
	assign tail = qptr_t'(tail_q);

	always_ff @(posedge clock) begin
		if (reset) begin
			head_q <= '0;
			tail_q <= '0;
		end else begin
			// push into a full ring is dropped
			if (push && !full) begin
				tail_q <= tail_q + 1'b1;
			end
			// pop from an empty ring is dropped
			if (pop && !empty) begin
				head_q <= head_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// File: queue_rows.sv
`timescale 1ns/100ps
`default_nettype none

module queue_rows #(
	parameter int  DEPTH     = 8,
	parameter type row_t     = logic [7:0],
	// set bits survive completion, the rest come from done_row
	parameter row_t KEEP_MASK = '0
) (
	input  wire logic                            clock,
	input  wire logic                            reset,
	input  wire logic                            alloc,
	input  wire mem_op_pkg::rob_id_t             alloc_rob_id,
	input  wire row_t                            alloc_row,
	input  wire lsq_pkg::qptr_t                  tail,
	input  wire lsq_pkg::qptr_t                  head,
	input  wire logic                            done,
	input  wire mem_op_pkg::rob_id_t             done_rob_id,
	input  wire row_t                            done_row,
	input  wire logic                            retire,
	output row_t [DEPTH-1:0]                     rows,
	output mem_op_pkg::rob_id_t [DEPTH-1:0]      row_rob_ids,
	output logic [DEPTH-1:0]                     row_valid,
	output logic [DEPTH-1:0]                     row_complete,
	output row_t                                 head_row
);
	import mem_op_pkg::*;

	localparam int IDX = $clog2(DEPTH);

	row_t [DEPTH-1:0]    row_q;
	rob_id_t [DEPTH-1:0] rob_q;
	logic [DEPTH-1:0]    valid_q;
	logic [DEPTH-1:0]    complete_q;
	logic [DEPTH-1:0]    done_hit;
	logic [IDX-1:0]      tail_idx;
	logic [IDX-1:0]      head_idx;

	// drop the wrap bit to get the row index
	assign tail_idx = tail[IDX-1:0];
	assign head_idx = head[IDX-1:0];

	////////////////////////////////////////
	// completion lookup by rob id
	////////////////////////////////////////

	always_comb begin
		for (int i = 0; i < DEPTH; i++) begin
			done_hit[i] = done && valid_q[i] && (rob_q[i] == done_rob_id);
		end
	end

	////////////////////////////////////////
	// row payload
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		for (int i = 0; i < DEPTH; i++) begin
			if (alloc && (tail_idx == IDX'(i))) begin
				row_q[i] <= alloc_row;
				rob_q[i] <= alloc_rob_id;
			end else if (done_hit[i]) begin
				// merge the completion into the dispatched fields
				row_q[i] <= row_t'((row_q[i] & KEEP_MASK) | (done_row & ~KEEP_MASK));
			end
		end
	end

	////////////////////////////////////////
	// valid and complete flags
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			valid_q    <= '0;
			complete_q <= '0;
		end else begin
			for (int i = 0; i < DEPTH; i++) begin
				if (alloc && (tail_idx == IDX'(i))) begin
					valid_q[i]    <= 1'b1;
					complete_q[i] <= 1'b0;
				end else if (retire && (head_idx == IDX'(i))) begin
					// head row leaves the queue
					valid_q[i]    <= 1'b0;
					complete_q[i] <= 1'b0;
				end else if (done_hit[i]) begin
					complete_q[i] <= 1'b1;
				end
			end
		end
	end

	assign rows         = row_q;
	assign row_rob_ids  = rob_q;
	assign row_valid    = valid_q;
	assign row_complete = complete_q;
	// oldest row, read in the same cycle as retire
	assign head_row     = row_q[head_idx];

endmodule

`default_nettype wire

// File: load_result.sv
`timescale 1ns/100ps
`default_nettype none

module load_result #(
	parameter int LQ_DEPTH = 8,
	parameter int SQ_DEPTH = 4
) (
	input  wire logic                               clock,
	input  wire logic                               reset,
	input  wire mem_op_pkg::exec_load_t             load_done,
	input  wire lsq_pkg::lq_entry_t [LQ_DEPTH-1:0]  load_rows,
	input  wire mem_op_pkg::rob_id_t [LQ_DEPTH-1:0] lq_rob_ids,
	input  wire logic [LQ_DEPTH-1:0]                lq_valid,
	input  wire lsq_pkg::sq_entry_t [SQ_DEPTH-1:0]  store_rows,
	input  wire logic [SQ_DEPTH-1:0]                sq_complete,
	input  wire lsq_pkg::qptr_t                     sq_head,
	output mem_op_pkg::load_result_t                result
);
	import mem_op_pkg::*;
	import lsq_pkg::*;

	localparam int SQ_IDX = $clog2(SQ_DEPTH);

	lq_entry_t       ld_row;
	logic            ld_hit;
	logic [SQ_IDX:0] older_cnt;
	logic [SQ_IDX:0] ring_pos;
	logic            fwd_hit;
	logic [XLEN-1:0] fwd_data;
	logic [XLEN-1:0] raw_data;
	logic [XLEN-1:0] ext_data;

	logic            result_valid_q;
	rob_id_t         result_rob_q;
	logic [XLEN-1:0] result_data_q;
	logic            result_fwd_q;

	// find the load row of the completing load
	always_comb begin
		ld_row = load_rows[0];
		ld_hit = 1'b0;
		for (int i = 0; i < LQ_DEPTH; i++) begin
			if (lq_valid[i] && (lq_rob_ids[i] == load_done.rob_id)) begin
				ld_row = load_rows[i];
				ld_hit = 1'b1;
			end
		end
	end

	////////////////////////////////////////
	// store to load forwarding
	////////////////////////////////////////

	always_comb begin
		// stores older than the load sit between sq head and store_tail
		older_cnt = ld_row.store_tail[SQ_IDX:0] - sq_head[SQ_IDX:0];
		ring_pos  = '0;
		fwd_hit   = 1'b0;
		fwd_data  = '0;
		// walk oldest first so the youngest match wins
		for (int k = 0; k < SQ_DEPTH; k++) begin
			ring_pos = sq_head[SQ_IDX:0] + (SQ_IDX+1)'(k);
			if (((SQ_IDX+1)'(k) < older_cnt)
					&& sq_complete[ring_pos[SQ_IDX-1:0]]
					&& (store_rows[ring_pos[SQ_IDX-1:0]].addr == load_done.addr)
					&& (store_rows[ring_pos[SQ_IDX-1:0]].size == ld_row.size)) begin
				fwd_hit  = 1'b1;
				fwd_data = store_rows[ring_pos[SQ_IDX-1:0]].data;
			end
		end
	end

	// sign or zero extension for byte and half loads
	always_comb begin
		raw_data = fwd_hit ? fwd_data : load_done.mem_data;
		case (ld_row.size)
			BYTE: ext_data = {{(XLEN-8){ld_row.is_signed & raw_data[7]}}, raw_data[7:0]};
			HALF: ext_data = {{(XLEN-16){ld_row.is_signed & raw_data[15]}}, raw_data[15:0]};
			default: ext_data = raw_data;
		endcase
	end

	////////////////////////////////////////
	// result register
	////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			result_valid_q <= 1'b0;
		end else begin
			// unknown rob id gives no result
			result_valid_q <= load_done.valid && ld_hit;
		end
	end

	always_ff @(posedge clock) begin
		result_rob_q  <= load_done.rob_id;
		result_data_q <= ext_data;
		result_fwd_q  <= fwd_hit;
	end

	assign result = '{
		valid:     result_valid_q,
		rob_id:    result_rob_q,
		data:      result_data_q,
		forwarded: result_fwd_q
	};

endmodule

`default_nettype wire

// File: lsq_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsq_top #(
	parameter int LQ_DEPTH = 8,
	parameter int SQ_DEPTH = 4
) (
	input  wire logic                     clock,
	input  wire logic                     reset,
	input  wire mem_op_pkg::dispatch_t    dispatch,
	input  wire mem_op_pkg::exec_load_t   load_done,
	input  wire mem_op_pkg::exec_store_t  store_done,
	input  wire logic                     retire_load,
	input  wire logic                     retire_store,
	output mem_op_pkg::load_result_t      load_result,
	output mem_op_pkg::store_commit_t     store_commit,
	output logic [lsq_pkg::PTR_BITS-1:0]  lq_free,
	output logic [lsq_pkg::PTR_BITS-1:0]  sq_free
);
	import mem_op_pkg::*;
	import lsq_pkg::*;

	// size, sign flag and store_tail come from dispatch and survive completion
	localparam lq_entry_t LQ_KEEP = '{
		size:       mem_size_t'(2'b11),
		is_signed:  1'b1,
		addr:       '0,
		mem_data:   '0,
		store_tail: '1
	};
	// store size is only known at dispatch
	localparam sq_entry_t SQ_KEEP = '{
		size: mem_size_t'(2'b11),
		addr: '0,
		data: '0
	};

	logic                      lq_push;
	logic                      sq_push;
	qptr_t                     lq_head;
	qptr_t                     lq_tail;
	qptr_t                     sq_head;
	qptr_t                     sq_tail;
	logic                      lq_full;
	logic                      lq_empty;
	logic                      sq_full;
	logic                      sq_empty;
	logic                      lq_alloc;
	logic                      sq_alloc;
	logic                      lq_retire;
	logic                      sq_retire;
	lq_entry_t                 lq_alloc_row;
	lq_entry_t                 lq_done_row;
	sq_entry_t                 sq_alloc_row;
	sq_entry_t                 sq_done_row;
	lq_entry_t [LQ_DEPTH-1:0]  lq_rows;
	rob_id_t [LQ_DEPTH-1:0]    lq_rob_ids;
	logic [LQ_DEPTH-1:0]       lq_valid;
	sq_entry_t [SQ_DEPTH-1:0]  sq_rows;
	logic [SQ_DEPTH-1:0]       sq_complete;
	sq_entry_t                 sq_head_row;

	////////////////////////////////////////
	// dispatch and retire steering
	////////////////////////////////////////

	assign lq_push   = dispatch.valid && !dispatch.is_store;
	assign sq_push   = dispatch.valid && dispatch.is_store;
	// rows follow the pointers, so full and empty gate them the same way
	assign lq_alloc  = lq_push && !lq_full;
	assign sq_alloc  = sq_push && !sq_full;
	assign lq_retire = retire_load && !lq_empty;
	assign sq_retire = retire_store && !sq_empty;

	// a new load remembers where the store ring ends
	assign lq_alloc_row = '{
		size:       dispatch.size,
		is_signed:  dispatch.is_signed,
		addr:       '0,
		mem_data:   '0,
		store_tail: sq_tail
	};
	assign lq_done_row = '{
		size:       BYTE,
		is_signed:  1'b0,
		addr:       load_done.addr,
		mem_data:   load_done.mem_data,
		store_tail: '0
	};
	assign sq_alloc_row = '{size: dispatch.size, addr: '0, data: '0};
	assign sq_done_row  = '{size: BYTE, addr: store_done.addr, data: store_done.data};

	////////////////////////////////////////
	// load queue
	////////////////////////////////////////

	queue_pointers #(
		.DEPTH (LQ_DEPTH)
	) lq_ptr_i (
		.clock (clock),
		.reset (reset),
		.push  (lq_push),
		.pop   (retire_load),
		.head  (lq_head),
		.tail  (lq_tail),
		.free  (lq_free),
		.full  (lq_full),
		.empty (lq_empty)
	);

	queue_rows #(
		.DEPTH     (LQ_DEPTH),
		.row_t     (lq_entry_t),
		.KEEP_MASK (LQ_KEEP)
	) lq_rows_i (
		.clock        (clock),
		.reset        (reset),
		.alloc        (lq_alloc),
		.alloc_rob_id (dispatch.rob_id),
		.alloc_row    (lq_alloc_row),
		.tail         (lq_tail),
		.head         (lq_head),
		.done         (load_done.valid),
		.done_rob_id  (load_done.rob_id),
		.done_row     (lq_done_row),
		.retire       (lq_retire),
		.rows         (lq_rows),
		.row_rob_ids  (lq_rob_ids),
		.row_valid    (lq_valid),
		.row_complete (),
		.head_row     ()
	);

	////////////////////////////////////////
	// store queue
	////////////////////////////////////////

	queue_pointers #(
		.DEPTH (SQ_DEPTH)
	) sq_ptr_i (
		.clock (clock),
		.reset (reset),
		.push  (sq_push),
		.pop   (retire_store),
		.head  (sq_head),
		.tail  (sq_tail),
		.free  (sq_free),
		.full  (sq_full),
		.empty (sq_empty)
	);

	queue_rows #(
		.DEPTH     (SQ_DEPTH),
		.row_t     (sq_entry_t),
		.KEEP_MASK (SQ_KEEP)
	) sq_rows_i (
		.clock        (clock),
		.reset        (reset),
		.alloc        (sq_alloc),
		.alloc_rob_id (dispatch.rob_id),
		.alloc_row    (sq_alloc_row),
		.tail         (sq_tail),
		.head         (sq_head),
		.done         (store_done.valid),
		.done_rob_id  (store_done.rob_id),
		.done_row     (sq_done_row),
		.retire       (sq_retire),
		.rows         (sq_rows),
		.row_rob_ids  (),
		.row_valid    (),
		.row_complete (sq_complete),
		.head_row     (sq_head_row)
	);

	// oldest store goes out combinationally with retire_store
	assign store_commit = '{
		valid: sq_retire,
		addr:  sq_head_row.addr,
		data:  sq_head_row.data,
		size:  sq_head_row.size
	};

	load_result #(
		.LQ_DEPTH (LQ_DEPTH),
		.SQ_DEPTH (SQ_DEPTH)
	) load_result_i (
		.clock       (clock),
		.reset       (reset),
		.load_done   (load_done),
		.load_rows   (lq_rows),
		.lq_rob_ids  (lq_rob_ids),
		.lq_valid    (lq_valid),
		.store_rows  (sq_rows),
		.sq_complete (sq_complete),
		.sq_head     (sq_head),
		.result      (load_result)
	);

endmodule

`default_nettype wire

// File: tb_lsq.sv
`timescale 1ns/100ps
`default_nettype none

module tb_lsq;
	import mem_op_pkg::*;

	localparam int LQ_DEPTH    = 8;
	localparam int SQ_DEPTH    = 4;
	localparam int NUM_OPS     = 300;
	// run length bound from the number of generated ops
	localparam int CYCLE_LIMIT = 4 * NUM_OPS + 100;

	// one in-flight op as the model sees it
	typedef struct packed {
		logic [31:0] seq;
		logic [31:0] st_order;
		rob_id_t     rob_id;
		mem_size_t   size;
		logic        is_signed;
		logic        complete;
		logic [31:0] addr;
		logic [31:0] data;
	} model_op_t;

	logic          clock;
	logic          reset;
	dispatch_t     dispatch;
	exec_load_t    load_done;
	exec_store_t   store_done;
	logic          retire_load;
	logic          retire_store;
	load_result_t  load_result;
	store_commit_t store_commit;
	logic [4:0]    lq_free;
	logic [4:0]    sq_free;

	// model queues with the oldest op at the front
	model_op_t     lq_model[$];
	model_op_t     sq_model[$];

	logic [31:0]   lcg_state = 32'h80409400;
	logic [31:0]   op_seq = '0;
	logic [31:0]   store_count = '0;
	rob_id_t       next_rob = '0;
	int            attempts = 0;
	int            cycle_count = 0;
	int            check_count = 0;
	int            mismatch_count = 0;
	logic          checks_on = 1'b0;

	// expectations for the cycle under check
	load_result_t  exp_res_cur = '0;
	load_result_t  exp_res_next = '0;
	store_commit_t exp_commit = '0;
	int            exp_lq_free = LQ_DEPTH;
	int            exp_sq_free = SQ_DEPTH;

	lsq_top #(
		.LQ_DEPTH (LQ_DEPTH),
		.SQ_DEPTH (SQ_DEPTH)
	) dut_i (
		.clock        (clock),
		.reset        (reset),
		.dispatch     (dispatch),
		.load_done    (load_done),
		.store_done   (store_done),
		.retire_load  (retire_load),
		.retire_store (retire_store),
		.load_result  (load_result),
		.store_commit (store_commit),
		.lq_free      (lq_free),
		.sq_free      (sq_free)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// upper half of the lcg state since its low bits cycle too fast
	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// four words so that addresses collide often
	function automatic logic [31:0] pick_addr();
		return 32'h0000_1000 + 32'(4 * (lcg_next() % 4));
	endfunction

	function automatic logic rob_in_use(rob_id_t id);
		foreach (lq_model[i]) begin
			if (lq_model[i].rob_id == id) return 1'b1;
		end
		foreach (sq_model[i]) begin
			if (sq_model[i].rob_id == id) return 1'b1;
		end
		return 1'b0;
	endfunction

	// expected load value from the forwarding and extension rules
	function automatic load_result_t expected_load_result(model_op_t ld, logic [31:0] addr,
			logic [31:0] mem_data);
		load_result_t res;
		logic [31:0]  value;
		logic         fwd;
		value = mem_data;
		fwd   = 1'b0;
		// the last hit in the oldest-first sq_model is the youngest older store
		foreach (sq_model[i]) begin
			if (sq_model[i].st_order < ld.st_order && sq_model[i].complete
					&& sq_model[i].addr == addr && sq_model[i].size == ld.size) begin
				value = sq_model[i].data;
				fwd   = 1'b1;
			end
		end
		if (ld.size == BYTE) begin
			value = ld.is_signed ? {{24{value[7]}}, value[7:0]} : {24'h0, value[7:0]};
		end else if (ld.size == HALF) begin
			value = ld.is_signed ? {{16{value[15]}}, value[15:0]} : {16'h0, value[15:0]};
		end
		res.valid     = 1'b1;
		res.rob_id    = ld.rob_id;
		res.data      = value;
		res.forwarded = fwd;
		return res;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("MISMATCH %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_counts();
		$display("checks %0d, mismatches %0d", check_count, mismatch_count);
	endtask

	////////////////////////////////////////
	// stimulus and model update
	////////////////////////////////////////

	// one cycle of random stimulus with the model following what the dut samples
	task automatic drive_cycle();
		dispatch_t   d;
		exec_load_t  ld;
		exec_store_t sd;
		logic        rl;
		logic        rs;
		logic        load_oldest;
		logic        is_store;
		logic        full;
		logic        push_op;
		int          cand[$];
		int          ld_idx;
		int          st_idx;
		model_op_t   op;
		d       = '0;
		ld      = '0;
		sd      = '0;
		rl      = 1'b0;
		rs      = 1'b0;
		push_op = 1'b0;
		op      = '0;
		ld_idx  = -1;
		st_idx  = -1;
		exp_commit   = '0;
		exp_res_next = '0;

		// load completion sees the store queue before this cycle's changes
		foreach (lq_model[i]) begin
			if (!lq_model[i].complete) cand.push_back(i);
		end
		if (cand.size() > 0 && lcg_next() % 4 != 0) begin
			ld_idx      = cand[lcg_next() % cand.size()];
			ld.valid    = 1'b1;
			ld.rob_id   = lq_model[ld_idx].rob_id;
			ld.addr     = pick_addr();
			ld.mem_data = {lcg_next(), lcg_next()};
			exp_res_next = expected_load_result(lq_model[ld_idx], ld.addr, ld.mem_data);
		end

		cand.delete();
		foreach (sq_model[i]) begin
			if (!sq_model[i].complete) cand.push_back(i);
		end
		if (cand.size() > 0 && lcg_next() % 4 != 0) begin
			st_idx    = cand[lcg_next() % cand.size()];
			sd.valid  = 1'b1;
			sd.rob_id = sq_model[st_idx].rob_id;
			sd.addr   = pick_addr();
			sd.data   = {lcg_next(), lcg_next()};
		end

		// only a complete oldest op retires
		if (lq_model.size() > 0 || sq_model.size() > 0) begin
			load_oldest = (sq_model.size() == 0)
				|| (lq_model.size() > 0 && lq_model[0].seq < sq_model[0].seq);
			if (load_oldest && lq_model[0].complete && lcg_next() % 4 != 0) begin
				rl = 1'b1;
			end else if (!load_oldest && sq_model[0].complete && lcg_next() % 4 != 0) begin
				rs               = 1'b1;
				exp_commit.valid = 1'b1;
				exp_commit.addr  = sq_model[0].addr;
				exp_commit.data  = sq_model[0].data;
				exp_commit.size  = sq_model[0].size;
			end
		end

		// dispatch that now and then targets a full queue
		if (attempts < NUM_OPS && lcg_next() % 4 != 0) begin
			is_store = (lcg_next() % 2) == 1;
			full = is_store ? (sq_model.size() == SQ_DEPTH) : (lq_model.size() == LQ_DEPTH);
			if (!full || lcg_next() % 4 == 0) begin
				while (rob_in_use(next_rob)) next_rob++;
				d.valid     = 1'b1;
				d.is_store  = is_store;
				d.rob_id    = next_rob;
				d.size      = mem_size_t'(lcg_next() % 3);
				d.is_signed = lcg_next() % 2;
				next_rob++;
				attempts++;
				if (!full) begin
					op.seq       = op_seq;
					op.st_order  = store_count;
					op.rob_id    = d.rob_id;
					op.size      = d.size;
					op.is_signed = d.is_signed;
					op_seq++;
					if (is_store) store_count++;
					push_op = 1'b1;
				end
			end
		end

		// completions go first because pops shift the indices
		if (ld_idx >= 0) begin
			lq_model[ld_idx].complete = 1'b1;
		end
		if (st_idx >= 0) begin
			sq_model[st_idx].complete = 1'b1;
			sq_model[st_idx].addr     = sd.addr;
			sq_model[st_idx].data     = sd.data;
		end
		if (rl) lq_model.pop_front();
		if (rs) sq_model.pop_front();
		if (push_op) begin
			if (is_store) sq_model.push_back(op);
			else lq_model.push_back(op);
		end

		dispatch     <= d;
		load_done    <= ld;
		store_done   <= sd;
		retire_load  <= rl;
		retire_store <= rs;
	endtask

	initial begin
		int idle;
		idle         = 0;
		reset        = 1'b1;
		dispatch     = '0;
		load_done    = '0;
		store_done   = '0;
		retire_load  = 1'b0;
		retire_store = 1'b0;
		repeat (3) @(posedge clock);
		reset <= 1'b0;

		while (idle < 3) begin
			@(posedge clock);
			// state after last cycle's inputs is what shows now
			exp_res_cur = exp_res_next;
			exp_lq_free = LQ_DEPTH - lq_model.size();
			exp_sq_free = SQ_DEPTH - sq_model.size();
			checks_on   = 1'b1;
			drive_cycle();
			if (attempts >= NUM_OPS && lq_model.size() == 0 && sq_model.size() == 0) begin
				idle++;
			end
		end

		@(posedge clock);
		report_counts();
		if (mismatch_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	////////////////////////////////////////
	// checker
	////////////////////////////////////////

	// outputs are settled at the falling edge
	always @(negedge clock) begin
		if (checks_on) begin
			check_value("lq_free", 32'(lq_free), 32'(exp_lq_free));
			check_value("sq_free", 32'(sq_free), 32'(exp_sq_free));
			check_value("load_result.valid", 32'(load_result.valid), 32'(exp_res_cur.valid));
			if (exp_res_cur.valid) begin
				check_value("load_result.rob_id", 32'(load_result.rob_id),
					32'(exp_res_cur.rob_id));
				check_value("load_result.data", load_result.data, exp_res_cur.data);
				check_value("load_result.forwarded", 32'(load_result.forwarded),
					32'(exp_res_cur.forwarded));
			end
			check_value("store_commit.valid", 32'(store_commit.valid), 32'(exp_commit.valid));
			if (exp_commit.valid) begin
				check_value("store_commit.addr", store_commit.addr, exp_commit.addr);
				check_value("store_commit.data", store_commit.data, exp_commit.data);
				check_value("store_commit.size", 32'(store_commit.size), 32'(exp_commit.size));
			end
		end
	end

	// run length guard
	always @(posedge clock) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("run did not finish within %0d cycles", CYCLE_LIMIT);
			report_counts();
			$display("STATUS: FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: vlog.f
mem_op_pkg.sv
lsq_pkg.sv
queue_pointers.sv
queue_rows.sv
load_result.sv
lsq_top.sv
tb_lsq.sv
